/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_pointwise_convolve
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_TEXT = === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation into $(LOG) and check it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@if grep -F -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed."; \
	else \
		cat $(LOG); \
		echo "Simulation failed."; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/channel_collector.sv */
`timescale 1ns/10ps

module channel_collector
    import pw_pkg::*;
#(
    parameter int out_channels = 3,
    parameter int right_shift = 0
) (
    input  logic                                 clock_i,
    input  logic                                 enable_i,
    input  logic                                 capture_i,
    input  logic [beat_width(out_channels)-1:0] capture_beat_i,
    input  acc_t                                 result_i,
    output activation_t [out_channels-1:0]       master_data_o
);

    typedef logic [beat_width(out_channels)-1:0] beat_t;

    activation_t field;
    activation_t slot [out_channels];

    // Scaling drops the low bits, and the high bits are discarded.
    assign field = activation_t'(result_i[right_shift +: activation_width]);

    // Earlier channels wait in their slots for the last one.
    for (genvar channel = 0; channel < out_channels - 1; channel++) begin : g_slot
        always_ff @(posedge clock_i) begin
            if (enable_i && capture_i && (capture_beat_i == beat_t'(channel))) begin
                slot[channel] <= field;
            end
        end
    end : g_slot

    // The last channel goes straight out with master valid.
    assign slot[out_channels-1] = field;

    always_comb begin
        for (int channel = 0; channel < out_channels; channel++) begin
            master_data_o[channel] = slot[channel];
        end
    end

    a_beat_in_range : assert property (
        @(posedge clock_i)
        capture_i |-> capture_beat_i <= beat_t'(out_channels - 1)
    );

endmodule : channel_collector

/* logic/mac_chain.sv */
`timescale 1ns/10ps

module mac_chain
    import pw_pkg::*;
#(
    parameter int in_channels = 4,
    parameter int out_channels = 3,
    parameter weight_t [out_channels-1:0][in_channels-1:0] weights = '0,
    parameter acc_t [out_channels-1:0] biases = '0
) (
    input  logic                          clock_i,
    input  logic                          reset_i,
    input  logic                          enable_i,
    input  logic                          slave_valid_i,
    input  activation_t [in_channels-1:0] slave_data_i,
    output acc_t                          result_o
);

    typedef logic [beat_width(out_channels)-1:0] beat_t;
    typedef weight_t [out_channels-1:0] column_t;

    // Weights of one input channel across all output channels.
    function automatic column_t column_of(int channel);
        column_t column;
        for (int out_channel = 0; out_channel < out_channels; out_channel++) begin
            column[out_channel] = weights[out_channel][channel];
        end
        return column;
    endfunction : column_of

    beat_t bias_beat;
    acc_t  bias_q;
    acc_t  bias_in;
    logic  valid_skew [in_channels];
    acc_t  cascade    [in_channels+1];

    // Same beat as the first slice, used to pick the bias.
    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            bias_beat <= '0;
        end else if (enable_i && slave_valid_i) begin
            bias_beat <= beat_t'(next_beat(int'(bias_beat), out_channels));
        end
    end

    // Two stages put the bias on the first cascade input in the same clock
    // as the first product.
    always_ff @(posedge clock_i) begin
        if (enable_i) begin
            bias_q  <= biases[bias_beat];
            bias_in <= bias_q;
        end
    end

    assign cascade[0]    = bias_in;
    assign valid_skew[0] = slave_valid_i;

    for (genvar channel = 0; channel < in_channels; channel++) begin : g_slice
        if (channel > 0) begin : g_valid_skew
            always_ff @(posedge clock_i) begin
                if (!reset_i) begin
                    valid_skew[channel] <= 1'b0;
                end else if (enable_i) begin
                    valid_skew[channel] <= valid_skew[channel-1];
                end
            end

            // Stale beats must not reach the slice counters after reset.
            a_skew_clear : assert property (
                @(posedge clock_i) $rose(reset_i) |-> !valid_skew[channel]
            );
        end : g_valid_skew

        mac_slice #(
            .out_channels  (out_channels),
            .skew          (channel),
            .column_weights(column_of(channel))
        ) i_mac_slice (
            .clock_i     (clock_i),
            .reset_i     (reset_i),
            .enable_i    (enable_i),
            .valid_i     (valid_skew[channel]),
            .activation_i(slave_data_i[channel]),
            .cascade_i   (cascade[channel]),
            .cascade_o   (cascade[channel+1])
        );
    end : g_slice

    assign result_o = cascade[in_channels];

endmodule : mac_chain

/* logic/mac_slice.sv */
`timescale 1ns/10ps

module mac_slice
    import pw_pkg::*;
#(
    parameter int out_channels = 3,
    parameter int skew = 0,
    parameter weight_t [out_channels-1:0] column_weights = '0
) (
    input  logic        clock_i,
    input  logic        reset_i,
    input  logic        enable_i,
    input  logic        valid_i,
    input  activation_t activation_i,
    input  acc_t        cascade_i,
    output acc_t        cascade_o
);

    typedef logic [beat_width(out_channels)-1:0] beat_t;

    activation_t act_pipe [skew+1];
    beat_t       beat;
    activation_t act_q;
    weight_t     weight_q;
    acc_t        product_q;
    acc_t        sum_q;

    // The activation is delayed so that it meets the partial sum from the
    // previous slice on the cascade path.
    assign act_pipe[0] = activation_i;

    for (genvar stage = 1; stage <= skew; stage++) begin : g_skew
        always_ff @(posedge clock_i) begin
            if (enable_i) begin
                act_pipe[stage] <= act_pipe[stage-1];
            end
        end
    end : g_skew

    // The beat counter runs in step with the skewed activation, so it always
    // names the output channel of the operand now at the slice input.
    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            beat <= '0;
        end else if (enable_i && valid_i) begin
            beat <= beat_t'(next_beat(int'(beat), out_channels));
        end
    end

    // Operand, product and sum registers.
    always_ff @(posedge clock_i) begin
        if (enable_i) begin
            act_q     <= act_pipe[skew];
            weight_q  <= column_weights[beat];
            product_q <= acc_t'(act_q) * acc_t'(weight_q);
            sum_q     <= product_q + cascade_i;
        end
    end

    assign cascade_o = sum_q;

endmodule : mac_slice

/* logic/pointwise_convolve.sv */
`timescale 1ns/10ps

module pointwise_convolve
    import pw_pkg::*;
#(
    parameter int in_channels = 4,
    parameter int out_channels = 3,
    parameter int right_shift = 0,
    parameter weight_t [out_channels-1:0][in_channels-1:0] weights = '0,
    parameter acc_t [out_channels-1:0] biases = '0
) (
    input  logic                           clock_i,
    input  logic                           reset_i,

    input  logic                           slave_valid_i,
    output logic                           slave_ready_o,
    input  activation_t [in_channels-1:0]  slave_data_i,

    output logic                           master_valid_o,
    input  logic                           master_ready_i,
    output activation_t [out_channels-1:0] master_data_o
);

    logic                                capture;
    logic [beat_width(out_channels)-1:0] capture_beat;
    acc_t                                result;

    // Downstream ready stalls the whole pipeline.
    pw_sequencer #(
        .in_channels (in_channels),
        .out_channels(out_channels)
    ) i_pw_sequencer (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .enable_i      (master_ready_i),
        .slave_valid_i (slave_valid_i),
        .slave_ready_o (slave_ready_o),
        .capture_o     (capture),
        .capture_beat_o(capture_beat),
        .master_valid_o(master_valid_o)
    );

    // One output channel per beat.
    mac_chain #(
        .in_channels (in_channels),
        .out_channels(out_channels),
        .weights     (weights),
        .biases      (biases)
    ) i_mac_chain (
        .clock_i      (clock_i),
        .reset_i      (reset_i),
        .enable_i     (master_ready_i),
        .slave_valid_i(slave_valid_i),
        .slave_data_i (slave_data_i),
        .result_o     (result)
    );

    channel_collector #(
        .out_channels(out_channels),
        .right_shift (right_shift)
    ) i_channel_collector (
        .clock_i       (clock_i),
        .enable_i      (master_ready_i),
        .capture_i     (capture),
        .capture_beat_i(capture_beat),
        .result_i      (result),
        .master_data_o (master_data_o)
    );

endmodule : pointwise_convolve

/* logic/pw_pkg.sv */
package pw_pkg;

    // Bit width of one activation on the input and output streams.
    localparam int activation_width = 8;

    // Bit width of one weight coefficient.
    localparam int weight_width = 8;

    // Width of the accumulator and of the cascade path between slices.
    // 24 bits hold 16 full-scale 8x8 products plus a bias without overflow.
    localparam int acc_width = 24;

    // Enabled clocks from the activation input of a slice to its cascade output.
    // The stages are the operand, product and sum registers.
    localparam int pipe_stages = 3;

    // One input or output channel value.
    typedef logic signed [activation_width-1:0] activation_t;

    // One coefficient of the weight matrix.
    typedef logic signed [weight_width-1:0] weight_t;

    // A partial sum, a bias or a cascade value.
    typedef logic signed [acc_width-1:0] acc_t;

    // Width of a counter that steps through count beats.
    // A single beat still needs one bit so that the counter type is legal.
    function automatic int beat_width(int count);
        return (count > 1) ? $clog2(count) : 1;
    endfunction : beat_width

    // Next value of a beat counter that wraps after count beats.
    function automatic int next_beat(int beat, int count);
        if (beat >= count - 1) begin
            return 0;
        end
        return beat + 1;
    endfunction : next_beat

endpackage : pw_pkg

/* logic/pw_sequencer.sv */
`timescale 1ns/10ps

module pw_sequencer
    import pw_pkg::*;
#(
    parameter int in_channels = 4,
    parameter int out_channels = 3
) (
    input  logic                                 clock_i,
    input  logic                                 reset_i,
    input  logic                                 enable_i,
    input  logic                                 slave_valid_i,
    output logic                                 slave_ready_o,
    output logic                                 capture_o,
    output logic [beat_width(out_channels)-1:0] capture_beat_o,
    output logic                                 master_valid_o
);

    typedef logic [beat_width(out_channels)-1:0] beat_t;

    // Enabled clocks from an input beat to its result at the chain output.
    localparam int latency = in_channels - 1 + pipe_stages;
    localparam beat_t last_beat = beat_t'(out_channels - 1);

    beat_t                in_beat;
    beat_t                out_beat;
    logic [latency:1]     valid_q;
    logic                 result_valid;

    // Each input vector is held for one beat per output channel.
    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            in_beat <= '0;
        end else if (enable_i && slave_valid_i) begin
            in_beat <= beat_t'(next_beat(int'(in_beat), out_channels));
        end
    end

    // The vector is released on its final beat only.
    assign slave_ready_o = enable_i && (in_beat == last_beat);

    // Valid follows the data through the slice chain.
    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            valid_q <= '0;
        end else if (enable_i) begin
            valid_q <= {valid_q[latency-1:1], slave_valid_i};
        end
    end

    assign result_valid = valid_q[latency];

    // Tells the collector which output channel the current result belongs to.
    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            out_beat <= '0;
        end else if (enable_i && result_valid) begin
            out_beat <= beat_t'(next_beat(int'(out_beat), out_channels));
        end
    end

    assign capture_o      = result_valid;
    assign capture_beat_o = out_beat;

    // The output vector is complete once the last channel arrives.
    assign master_valid_o = result_valid && (out_beat == last_beat);

    // The source must hold its vector until the final beat accepts it.
    a_valid_held : assert property (
        @(posedge clock_i) disable iff (!reset_i)
        slave_valid_i && !slave_ready_o |=> slave_valid_i
    );

endmodule : pw_sequencer

/* test/tb_pointwise_convolve.sv */
`timescale 1ns/10ps

module tb_pointwise_convolve import pw_pkg::*; ();

    localparam int in_channels = 4;
    localparam int out_channels = 3;
    localparam int right_shift = 2;
    localparam int clock_period = 20;
    localparam int reset_cycles = 8;
    localparam int depth = in_channels - 1 + pipe_stages;
    localparam int cadence_vectors = 6;
    localparam int stream_vectors = 50;
    localparam int stall_vectors = 20;
    localparam int total_vectors = 1 + cadence_vectors + stream_vectors + stall_vectors + 2;
    localparam int timeout_cycles = (total_vectors * out_channels + depth + reset_cycles) * 4;

    typedef activation_t [in_channels-1:0] in_vec_t;
    typedef activation_t [out_channels-1:0] out_vec_t;

    // Rows are output channels 2 down to 0, columns are input channels 3 down to 0.
    localparam weight_t [out_channels-1:0][in_channels-1:0] weight_matrix = {
        8'sd7,   -8'sd127, 8'sd127, -8'sd3,
        -8'sd20, 8'sd15,   -8'sd64, 8'sd90,
        8'sd1,   -8'sd2,   8'sd3,   -8'sd4
    };

    localparam acc_t [out_channels-1:0] bias_vector = {
        24'sd1000, -24'sd513, 24'sd5
    };

    logic     clock_i;
    logic     reset_i;
    logic     slave_valid_i;
    logic     slave_ready_o;
    in_vec_t  slave_data_i;
    logic     master_valid_o;
    logic     master_ready_i;
    out_vec_t master_data_o;

    integer   seed = 32'hf3cc83c2;
    in_vec_t  sent_q [$];
    int       checked_count;
    logic     stall_mode;
    logic     check_cadence;
    logic     ready_last;
    out_vec_t expected_out;

    pointwise_convolve #(
        .in_channels (in_channels),
        .out_channels(out_channels),
        .right_shift (right_shift),
        .weights     (weight_matrix),
        .biases      (bias_vector)
    ) i_pointwise_convolve (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .slave_valid_i (slave_valid_i),
        .slave_ready_o (slave_ready_o),
        .slave_data_i  (slave_data_i),
        .master_valid_o(master_valid_o),
        .master_ready_i(master_ready_i),
        .master_data_o (master_data_o)
    );

    // Bias plus the weighted sum, then the activation-wide field above the shift.
    function automatic out_vec_t ref_convolve(in_vec_t activations);
        out_vec_t result;
        int       total;
        acc_t     sum;
        for (int o = 0; o < out_channels; o++) begin
            total = int'(acc_t'(bias_vector[o]));
            for (int i = 0; i < in_channels; i++) begin
                total += int'(weight_t'(weight_matrix[o][i])) * int'(activation_t'(activations[i]));
            end
            sum = acc_t'(total);
            result[o] = sum[right_shift +: activation_width];
        end
        return result;
    endfunction

    function automatic in_vec_t random_vector();
        in_vec_t vec;
        for (int i = 0; i < in_channels; i++) begin
            vec[i] = activation_t'($random(seed));
        end
        return vec;
    endfunction

    function automatic in_vec_t fill_vector(activation_t value);
        in_vec_t vec;
        for (int i = 0; i < in_channels; i++) begin
            vec[i] = value;
        end
        return vec;
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %b, actual %b",
                     $time, name, expected, actual);
            stop_run("A handshake flag differs from its expected value.");
        end
    endtask

    task automatic check_vector(input string name, input out_vec_t expected,
                                input out_vec_t actual);
        for (int ch = 0; ch < out_channels; ch++) begin
            if (actual[ch] !== expected[ch]) begin
                $display("MISMATCH at %0t ns: %s[%0d] expected %0d, actual %0d",
                         $time, name, ch, expected[ch], actual[ch]);
                stop_run("An output channel differs from the reference model.");
            end
        end
    endtask

    // Presents one vector on the next falling edge and holds it until accepted.
    task automatic send_vector(input in_vec_t data);
        int waited;
        @(negedge clock_i);
        slave_valid_i = 1'b1;
        slave_data_i  = data;
        waited = 0;
        do begin
            @(posedge clock_i);
            waited++;
        end while (!slave_ready_o);
        sent_q.push_back(data);
        if (check_cadence && waited != out_channels) begin
            $display("Input vector accepted after %0d cycles instead of %0d.",
                     waited, out_channels);
            stop_run("The acceptance cadence is wrong.");
        end
    endtask

    task automatic release_input();
        @(negedge clock_i);
        slave_valid_i = 1'b0;
        slave_data_i  = '0;
    endtask

    task automatic wait_drain();
        while (sent_q.size() != 0) begin
            @(posedge clock_i);
        end
        repeat (2) @(posedge clock_i);
    endtask

    initial begin
        clock_i = 1'b0;
        forever #(clock_period / 2) clock_i = ~clock_i;
    end

    // Downstream ready, either held high or toggled at random.
    initial begin
        logic [31:0] rnd;
        master_ready_i = 1'b1;
        forever begin
            @(negedge clock_i);
            if (stall_mode) begin
                rnd = $random(seed);
                master_ready_i = rnd[0];
            end else begin
                master_ready_i = 1'b1;
            end
        end
    end

    // Compares every transferred output vector with the oldest accepted input.
    always @(posedge clock_i) begin
        if (reset_i && master_valid_o && master_ready_i) begin
            if (sent_q.size() == 0) begin
                stop_run("An output vector appeared with no accepted input pending.");
            end else begin
                expected_out = ref_convolve(sent_q.pop_front());
                check_vector("master_data_o", expected_out, master_data_o);
                checked_count++;
            end
        end
    end

    always @(posedge clock_i) begin
        if (reset_i) begin
            if (ready_last) begin
                check_bit("slave_ready_o on consecutive cycles", 1'b0, slave_ready_o);
            end
            if (!master_ready_i) begin
                check_bit("slave_ready_o while stalled", 1'b0, slave_ready_o);
            end
            ready_last = slave_ready_o;
        end else begin
            ready_last = 1'b0;
        end
    end

    initial begin
        #(timeout_cycles * clock_period);
        $display("Timeout: the run did not finish within %0d clock cycles.", timeout_cycles);
        $display("=== FAIL ===");
        $fatal(1, "Watchdog expired.");
    end

    initial begin
        reset_i        = 1'b0;
        slave_valid_i  = 1'b0;
        slave_data_i   = '0;
        stall_mode     = 1'b0;
        check_cadence  = 1'b0;
        checked_count  = 0;

        // The first edge loads the reset values.
        @(posedge clock_i);
        repeat (reset_cycles - 1) begin
            @(posedge clock_i);
            check_bit("master_valid_o in reset", 1'b0, master_valid_o);
            check_bit("slave_ready_o in reset", 1'b0, slave_ready_o);
        end
        @(negedge clock_i);
        reset_i = 1'b1;
        repeat (2) begin
            @(posedge clock_i);
            check_bit("master_valid_o after reset", 1'b0, master_valid_o);
            check_bit("slave_ready_o after reset", 1'b0, slave_ready_o);
        end

        // Negative sums and products that overflow the output field.
        send_vector({-8'sd100, 8'sd127, -8'sd1, 8'sd64});
        release_input();
        wait_drain();

        check_cadence = 1'b1;
        repeat (cadence_vectors) send_vector(random_vector());
        release_input();
        wait_drain();

        repeat (stream_vectors) send_vector(random_vector());
        release_input();
        wait_drain();
        check_cadence = 1'b0;

        stall_mode = 1'b1;
        repeat (stall_vectors) send_vector(random_vector());
        release_input();
        wait_drain();
        stall_mode = 1'b0;

        send_vector(fill_vector(8'sd127));
        send_vector(fill_vector(activation_t'(-128)));
        release_input();
        wait_drain();

        if (checked_count == total_vectors && sent_q.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("Only %0d of %0d vectors were checked.", checked_count, total_vectors);
            $display("=== FAIL ===");
            $fatal(1, "Vector count does not match.");
        end
    end

endmodule : tb_pointwise_convolve

/* vlog.f */
logic/pw_pkg.sv
logic/pw_sequencer.sv
logic/mac_slice.sv
logic/mac_chain.sv
logic/channel_collector.sv
logic/pointwise_convolve.sv
test/tb_pointwise_convolve.sv
